//--- la_mmu.f
la_mmu_pkg.sv
la_mmu_ctrl.sv
la_mmu_tlb.sv
la_mmu_xlate.sv
la_mmu_top.sv
la_mmu_checker.sv
tb_la_mmu.sv

//--- Bender.yml
package:
  name: la_mmu

sources:
  - la_mmu_pkg.sv
  - la_mmu_ctrl.sv
  - la_mmu_tlb.sv
  - la_mmu_xlate.sv
  - la_mmu_top.sv
  - target: test
    files:
      - la_mmu_checker.sv
      - tb_la_mmu.sv

//--- tb_la_mmu.sv
`timescale 1ns/100ps

module tb_la_mmu;

    import la_mmu_pkg::*;

    localparam int TLB_ENTRIES = 16;
    localparam int CREDITS     = 4;
    localparam int N_RAND      = 20;
    // direct, window and credit phases use N_RAND, three tlb sweeps of 12
    localparam int NUM_REQ     = 3 * N_RAND + 36 + CREDITS + 2;

    logic   clk;
    logic   rst_n;
    logic   in_valid;
    logic   in_ready;
    vaddr_t in_vaddr;
    logic   in_store;
    logic   out_valid;
    paddr_t out_paddr;
    logic   out_ex;
    ecode_t out_ecode;
    logic   credit_return;
    logic   crmd_da;
    logic   crmd_pg;
    plv_t   crmd_plv;
    asid_t  cur_asid;
    seg_t   dmw0_vseg;
    seg_t   dmw0_pseg;
    seg_t   dmw1_vseg;
    seg_t   dmw1_pseg;
    logic   dmw0_plv0;
    logic   dmw0_plv3;
    logic   dmw1_plv0;
    logic   dmw1_plv3;
    logic   tlb_we;
    logic   [$clog2(TLB_ENTRIES)-1:0] tlb_windex;
    vppn_t  tlb_wvppn;
    asid_t  tlb_wasid;
    logic   tlb_wg;
    logic   tlb_wvalid_e;
    ppn_t   tlb_wppn0;
    ppn_t   tlb_wppn1;
    plv_t   tlb_wplv0;
    plv_t   tlb_wplv1;
    logic   tlb_wv0;
    logic   tlb_wd0;
    logic   tlb_wv1;
    logic   tlb_wd1;
    logic   invtlb_all;

    // shadow tlb, tag is {vppn, asid, g}, each half is {ppn, plv, v, d}
    logic [TLB_ENTRIES-1:0] m_e;
    logic [29:0]            m_tag  [TLB_ENTRIES];
    logic [23:0]            m_half [TLB_ENTRIES][2];

    // expected results as {ex, ecode, paddr}, in acceptance order
    logic [38:0] exp_q [$];
    logic [38:0] exp_res;
    logic [31:0] stim_seed = 32'hd287cab8;
    logic [31:0] sink_seed = 32'hd287cab8;
    vppn_t       sweep_vppn [3] = '{19'h00123, 19'h00456, 19'h00789};
    int          held       = 0;
    int          out_cnt    = 0;
    int          ret_mode   = 1;
    int          base_cnt;

    la_mmu_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    function automatic logic [38:0] ref_xlate(input vaddr_t va, input logic st);
        int          idx;
        logic [23:0] pg;
        idx = -1;
        if (crmd_da) begin
            return {1'b0, ECODE_NONE, va};
        end
        if (va[31:29] == dmw0_vseg
            && ((crmd_plv == 2'd0 && dmw0_plv0) || (crmd_plv == 2'd3 && dmw0_plv3))) begin
            return {1'b0, ECODE_NONE, dmw0_pseg, va[28:0]};
        end
        if (va[31:29] == dmw1_vseg
            && ((crmd_plv == 2'd0 && dmw1_plv0) || (crmd_plv == 2'd3 && dmw1_plv3))) begin
            return {1'b0, ECODE_NONE, dmw1_pseg, va[28:0]};
        end
        // scan downwards so the lowest match is kept
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (m_e[i] && m_tag[i][29:11] == va[31:13]
                && (m_tag[i][0] || m_tag[i][10:1] == cur_asid)) begin
                idx = i;
            end
        end
        if (idx < 0) begin
            return {1'b1, ECODE_TLBR, 32'h0};
        end
        pg = m_half[idx][va[12]];
        if (!pg[1]) begin
            return {1'b1, st ? ECODE_PIS : ECODE_PIL, 32'h0};
        end else if (crmd_plv > pg[3:2]) begin
            return {1'b1, ECODE_PPI, 32'h0};
        end else if (st && !pg[0]) begin
            return {1'b1, ECODE_PME, 32'h0};
        end
        return {1'b0, ECODE_NONE, pg[23:4], va[11:0]};
    endfunction

    task automatic send(input vaddr_t va, input logic st);
        in_valid = 1'b1;
        in_vaddr = va;
        in_store = st;
        @(posedge clk);
        while (!in_ready) begin
            @(posedge clk);
        end
        #2;
        in_valid = 1'b0;
    endtask

    // wait until every result is out and every credit is back
    task automatic drain();
        @(posedge clk);
        while (exp_q.size() != 0 || held != 0) begin
            @(posedge clk);
        end
        #2;
    endtask

    task automatic tlb_write(input int idx, input vppn_t vppn, input asid_t asid, input logic g,
                             input logic [23:0] even, input logic [23:0] odd);
        tlb_we       = 1'b1;
        tlb_windex   = 4'(idx);
        tlb_wvppn    = vppn;
        tlb_wasid    = asid;
        tlb_wg       = g;
        tlb_wvalid_e = 1'b1;
        {tlb_wppn0, tlb_wplv0, tlb_wv0, tlb_wd0} = even;
        {tlb_wppn1, tlb_wplv1, tlb_wv1, tlb_wd1} = odd;
        @(posedge clk);
        #2;
        tlb_we         = 1'b0;
        m_e[idx]       = 1'b1;
        m_tag[idx]     = {vppn, asid, g};
        m_half[idx][0] = even;
        m_half[idx][1] = odd;
    endtask

    // every tagged vppn, both halves, load and store
    task automatic tlb_sweep();
        for (int i = 0; i < 3; i++) begin
            for (int h = 0; h < 2; h++) begin
                for (int s = 0; s < 2; s++) begin
                    stim_seed = lcg(stim_seed);
                    send({sweep_vppn[i], h[0], stim_seed[11:0]}, s[0]);
                end
            end
        end
        drain();
    endtask

    // sink model, returns credits for results it has taken
    initial begin
        forever begin
            @(posedge clk);
            #2;
            sink_seed     = lcg(sink_seed);
            credit_return = (held != 0) && (ret_mode == 1 || (ret_mode == 2 && sink_seed[16]));
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            held = held + int'(out_valid) - int'(credit_return);
            if (in_valid && in_ready) begin
                exp_q.push_back(ref_xlate(in_vaddr, in_store));
            end
            if (out_valid) begin
                out_cnt++;
                if (exp_q.size() == 0) begin
                    $display("a result came out with no request pending");
                    abort_run();
                end else begin
                    exp_res = exp_q.pop_front();
                    assert ({out_ex, out_ecode, out_paddr} == exp_res) else begin
                        $display("ERROR %0t: want ex=%b ec=%h pa=%h, got ex=%b ec=%h pa=%h",
                                 $time, exp_res[38], exp_res[37:32], exp_res[31:0],
                                 out_ex, out_ecode, out_paddr);
                        abort_run();
                    end
                end
            end
        end
    end

    always @(negedge clk) begin
        if (dut_i.checker_i.err_cnt != 0) begin
            $display("an assertion in the bound checker failed");
            abort_run();
        end
    end

    initial begin
        #((NUM_REQ * 40 + 2000) * 20);
        $display("timeout, the run did not finish within %0d cycles", NUM_REQ * 40 + 2000);
        abort_run();
    end

    initial begin
        {in_valid, in_vaddr, in_store, credit_return, invtlb_all} = '0;
        {crmd_da, crmd_pg, crmd_plv, cur_asid} = {1'b1, 1'b0, 2'd0, 10'h021};
        {dmw0_vseg, dmw0_pseg, dmw0_plv0, dmw0_plv3} = {3'h4, 3'h1, 1'b1, 1'b0};
        {dmw1_vseg, dmw1_pseg, dmw1_plv0, dmw1_plv3} = {3'h5, 3'h2, 1'b0, 1'b1};
        {tlb_we, tlb_windex, tlb_wvppn, tlb_wasid, tlb_wg, tlb_wvalid_e} = '0;
        {tlb_wppn0, tlb_wplv0, tlb_wv0, tlb_wd0, tlb_wppn1, tlb_wplv1, tlb_wv1, tlb_wd1} = '0;
        m_e   = '0;
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        repeat (5) begin
            @(posedge clk);
            assert (!out_valid && in_ready) else begin
                $display("ERROR %0t: idle out_valid=%b in_ready=%b", $time, out_valid, in_ready);
                abort_run();
            end
        end
        #2;
        // direct mode
        repeat (N_RAND) begin
            stim_seed = lcg(stim_seed);
            send(stim_seed, stim_seed[7]);
        end
        drain();
        // windows, seg 4 only for plv0 and seg 5 only for plv3
        crmd_da = 1'b0;
        crmd_pg = 1'b1;
        for (int p = 0; p < 2; p++) begin
            crmd_plv = p ? 2'd3 : 2'd0;
            repeat (N_RAND / 2) begin
                stim_seed = lcg(stim_seed);
                send({stim_seed[3] ? 3'h4 : 3'h5, stim_seed[28:0]}, stim_seed[30]);
            end
            drain();
        end
        crmd_plv = 2'd0;
        tlb_write(0, 19'h00123, 10'h021, 1'b0, {20'h11111, 2'd0, 1'b1, 1'b1},
                  {20'h22222, 2'd3, 1'b1, 1'b0});
        // invalid even page with a low plv, so v wins over plv at user level
        tlb_write(1, 19'h00456, 10'h3ff, 1'b1, {20'h33333, 2'd0, 1'b0, 1'b1},
                  {20'h44444, 2'd0, 1'b1, 1'b0});
        tlb_write(2, 19'h00789, 10'h005, 1'b0, {20'h55555, 2'd3, 1'b1, 1'b1},
                  {20'h55556, 2'd3, 1'b1, 1'b1});
        // same page pair as entry 0, never selected
        tlb_write(5, 19'h00123, 10'h021, 1'b1, {20'h66666, 2'd3, 1'b1, 1'b1},
                  {20'h77777, 2'd3, 1'b1, 1'b1});
        tlb_sweep();
        crmd_plv = 2'd3;
        tlb_sweep();
        crmd_plv   = 2'd0;
        invtlb_all = 1'b1;
        @(posedge clk);
        #2;
        invtlb_all = 1'b0;
        m_e        = '0;
        tlb_sweep();
        // credit starvation, then random returns
        crmd_da  = 1'b1;
        ret_mode = 0;
        base_cnt = out_cnt;
        repeat (CREDITS + 2) begin
            stim_seed = lcg(stim_seed);
            send(stim_seed, 1'b0);
        end
        repeat (4) @(posedge clk);
        assert (out_cnt - base_cnt == CREDITS && !in_ready) else begin
            $display("ERROR %0t: stalled with %0d results, in_ready=%b",
                     $time, out_cnt - base_cnt, in_ready);
            abort_run();
        end
        ret_mode = 2;
        #2;
        repeat (N_RAND) begin
            stim_seed = lcg(stim_seed);
            send(stim_seed, stim_seed[9]);
        end
        drain();
        if (dut_i.checker_i.err_cnt == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("an assertion in the bound checker failed");
            abort_run();
        end
    end

endmodule

//--- la_mmu_checker.sv
`timescale 1ns/100ps

module la_mmu_checker #(
    parameter int CREDITS = 4
) (
    input logic clk,
    input logic rst_n,
    input logic in_ready,
    input logic out_valid,
    input logic credit_return
);

    // results issued and not yet credited back by the sink
    int outstanding;
    int err_cnt = 0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(out_valid) - int'(credit_return);
        end
    end

    credit_limit: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> outstanding < CREDITS)
    else begin
        $error("out_valid fired with every credit in use");
        err_cnt++;
    end

    no_unknown: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown({in_ready, out_valid}))
    else begin
        $error("in_ready or out_valid is unknown outside reset");
        err_cnt++;
    end

    // first cycle out of reset
    quiet_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !out_valid)
    else begin
        $error("out_valid high right after reset");
        err_cnt++;
    end

endmodule

bind la_mmu_top la_mmu_checker #(.CREDITS(CREDITS)) checker_i (.*);

//--- la_mmu_top.sv
`timescale 1ns/100ps

module la_mmu_top #(
    parameter int TLB_ENTRIES = 16,
    parameter int CREDITS     = 4
) (
    input  logic                           clk,
    input  logic                           rst_n,

    // request, valid/ready
    input  logic                           in_valid,
    output logic                           in_ready,
    input  la_mmu_pkg::vaddr_t             in_vaddr,
    input  logic                           in_store,

    // result, credit based
    output logic                           out_valid,
    output la_mmu_pkg::paddr_t             out_paddr,
    output logic                           out_ex,
    output la_mmu_pkg::ecode_t             out_ecode,
    input  logic                           credit_return,

    // crmd and asid
    input  logic                           crmd_da,
    input  logic                           crmd_pg,
    input  la_mmu_pkg::plv_t               crmd_plv,
    input  la_mmu_pkg::asid_t              cur_asid,

    // direct-mapped windows
    input  la_mmu_pkg::seg_t               dmw0_vseg,
    input  la_mmu_pkg::seg_t               dmw0_pseg,
    input  logic                           dmw0_plv0,
    input  logic                           dmw0_plv3,
    input  la_mmu_pkg::seg_t               dmw1_vseg,
    input  la_mmu_pkg::seg_t               dmw1_pseg,
    input  logic                           dmw1_plv0,
    input  logic                           dmw1_plv3,

    // tlb write and invalidate
    input  logic                           tlb_we,
    input  logic [$clog2(TLB_ENTRIES)-1:0] tlb_windex,
    input  la_mmu_pkg::vppn_t              tlb_wvppn,
    input  la_mmu_pkg::asid_t              tlb_wasid,
    input  logic                           tlb_wg,
    input  logic                           tlb_wvalid_e,
    input  la_mmu_pkg::ppn_t               tlb_wppn0,
    input  la_mmu_pkg::plv_t               tlb_wplv0,
    input  logic                           tlb_wv0,
    input  logic                           tlb_wd0,
    input  la_mmu_pkg::ppn_t               tlb_wppn1,
    input  la_mmu_pkg::plv_t               tlb_wplv1,
    input  logic                           tlb_wv1,
    input  logic                           tlb_wd1,
    input  logic                           invtlb_all
);

    import la_mmu_pkg::*;

    // stage enables from control
    logic  s1_load;
    logic  s2_load;

    // search request and tlb result
    vppn_t search_vppn;
    logic  search_odd;
    logic  hit;
    ppn_t  ppn;
    plv_t  plv;
    logic  v;
    logic  d;

    // port names match the nets above
    la_mmu_ctrl #(
        .CREDITS (CREDITS)
    ) ctrl_i (
        .*
    );

    la_mmu_tlb #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) tlb_i (
        .*
    );

    la_mmu_xlate xlate_i (
        .*
    );

endmodule

//--- la_mmu_xlate.sv
`timescale 1ns/100ps

module la_mmu_xlate (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               s1_load,
    input  logic               s2_load,

    input  la_mmu_pkg::vaddr_t in_vaddr,
    input  logic               in_store,

    // mode and windows
    input  logic               crmd_da,
    input  logic               crmd_pg,
    input  la_mmu_pkg::plv_t   crmd_plv,
    input  la_mmu_pkg::seg_t   dmw0_vseg,
    input  la_mmu_pkg::seg_t   dmw0_pseg,
    input  logic               dmw0_plv0,
    input  logic               dmw0_plv3,
    input  la_mmu_pkg::seg_t   dmw1_vseg,
    input  la_mmu_pkg::seg_t   dmw1_pseg,
    input  logic               dmw1_plv0,
    input  logic               dmw1_plv3,

    // tlb search
    output la_mmu_pkg::vppn_t  search_vppn,
    output logic               search_odd,
    input  logic               hit,
    input  la_mmu_pkg::ppn_t   ppn,
    input  la_mmu_pkg::plv_t   plv,
    input  logic               v,
    input  logic               d,

    output la_mmu_pkg::paddr_t out_paddr,
    output logic               out_ex,
    output la_mmu_pkg::ecode_t out_ecode
);

    import la_mmu_pkg::*;

    vaddr_t s1_vaddr;
    logic   s1_store;
    logic   direct;
    logic   dmw0_hit;
    logic   dmw1_hit;
    paddr_t xl_paddr;
    logic   xl_ex;
    ecode_t xl_ecode;

    function automatic logic win_match(seg_t va_seg, seg_t vseg, logic en0, logic en3,
                                       plv_t cur_plv);
        return (va_seg == vseg) && ((cur_plv == PLV_KERNEL && en0)
                                    || (cur_plv == PLV_USER && en3));
    endfunction

    always_ff @(posedge clk) begin
        if (s1_load) begin
            s1_vaddr <= in_vaddr;
            s1_store <= in_store;
        end
    end

    assign search_vppn = s1_vaddr[31:13];
    assign search_odd  = s1_vaddr[PAGE_OFS_W];

    // da=0 with pg=0 is undefined, treat it as direct
    assign direct   = crmd_da || !crmd_pg;
    assign dmw0_hit = win_match(s1_vaddr[31:29], dmw0_vseg, dmw0_plv0, dmw0_plv3, crmd_plv);
    assign dmw1_hit = win_match(s1_vaddr[31:29], dmw1_vseg, dmw1_plv0, dmw1_plv3, crmd_plv);

    always_comb begin
        xl_ex    = 1'b0;
        xl_ecode = ECODE_NONE;
        if (direct) begin
            xl_paddr = s1_vaddr;
        end else if (dmw0_hit) begin
            xl_paddr = {dmw0_pseg, s1_vaddr[28:0]};
        end else if (dmw1_hit) begin
            xl_paddr = {dmw1_pseg, s1_vaddr[28:0]};
        end else begin
            xl_paddr = {ppn, s1_vaddr[PAGE_OFS_W-1:0]};
            // exception checks in priority order
            if (!hit) begin
                xl_ex    = 1'b1;
                xl_ecode = ECODE_TLBR;
            end else if (!v) begin
                xl_ex    = 1'b1;
                xl_ecode = s1_store ? ECODE_PIS : ECODE_PIL;
            end else if (crmd_plv > plv) begin
                xl_ex    = 1'b1;
                xl_ecode = ECODE_PPI;
            end else if (s1_store && !d) begin
                xl_ex    = 1'b1;
                xl_ecode = ECODE_PME;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_paddr <= '0;
            out_ex    <= 1'b0;
            out_ecode <= ECODE_NONE;
        end else if (s2_load) begin
            out_paddr <= xl_ex ? '0 : xl_paddr;
            out_ex    <= xl_ex;
            out_ecode <= xl_ecode;
        end
    end

endmodule

//--- la_mmu_tlb.sv
`timescale 1ns/100ps

module la_mmu_tlb #(
    parameter int TLB_ENTRIES = 16
) (
    input  logic                           clk,
    input  logic                           rst_n,

    // indexed write
    input  logic                           tlb_we,
    input  logic [$clog2(TLB_ENTRIES)-1:0] tlb_windex,
    input  la_mmu_pkg::vppn_t              tlb_wvppn,
    input  la_mmu_pkg::asid_t              tlb_wasid,
    input  logic                           tlb_wg,
    input  logic                           tlb_wvalid_e,
    input  la_mmu_pkg::ppn_t               tlb_wppn0,
    input  la_mmu_pkg::plv_t               tlb_wplv0,
    input  logic                           tlb_wv0,
    input  logic                           tlb_wd0,
    input  la_mmu_pkg::ppn_t               tlb_wppn1,
    input  la_mmu_pkg::plv_t               tlb_wplv1,
    input  logic                           tlb_wv1,
    input  logic                           tlb_wd1,

    // invtlb op 0
    input  logic                           invtlb_all,

    // search port
    input  la_mmu_pkg::vppn_t              search_vppn,
    input  logic                           search_odd,
    input  la_mmu_pkg::asid_t              cur_asid,
    output logic                           hit,
    output la_mmu_pkg::ppn_t               ppn,
    output la_mmu_pkg::plv_t               plv,
    output logic                           v,
    output logic                           d
);

    import la_mmu_pkg::*;

    localparam int IDX_W = $clog2(TLB_ENTRIES);

    logic [TLB_ENTRIES-1:0] tlb_e;
    vppn_t                  tlb_vppn [TLB_ENTRIES];
    asid_t                  tlb_asid [TLB_ENTRIES];
    logic                   tlb_g    [TLB_ENTRIES];

    // second index picks the even (0) or odd (1) page
    ppn_t                   tlb_ppn  [TLB_ENTRIES][2];
    plv_t                   tlb_plv  [TLB_ENTRIES][2];
    logic                   tlb_v    [TLB_ENTRIES][2];
    logic                   tlb_d    [TLB_ENTRIES][2];

    logic [TLB_ENTRIES-1:0] match;
    logic [IDX_W-1:0]       sel_idx;

    // a write in the same cycle as invalidate-all keeps its own e bit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tlb_e <= '0;
        end else begin
            if (invtlb_all) begin
                tlb_e <= '0;
            end
            if (tlb_we) begin
                tlb_e[tlb_windex] <= tlb_wvalid_e;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tlb_we) begin
            tlb_vppn[tlb_windex]   <= tlb_wvppn;
            tlb_asid[tlb_windex]   <= tlb_wasid;
            tlb_g[tlb_windex]      <= tlb_wg;
            tlb_ppn[tlb_windex][0] <= tlb_wppn0;
            tlb_plv[tlb_windex][0] <= tlb_wplv0;
            tlb_v[tlb_windex][0]   <= tlb_wv0;
            tlb_d[tlb_windex][0]   <= tlb_wd0;
            tlb_ppn[tlb_windex][1] <= tlb_wppn1;
            tlb_plv[tlb_windex][1] <= tlb_wplv1;
            tlb_v[tlb_windex][1]   <= tlb_wv1;
            tlb_d[tlb_windex][1]   <= tlb_wd1;
        end
    end

    // parallel compare of every entry
    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            match[i] = tlb_e[i] && (tlb_vppn[i] == search_vppn)
                       && (tlb_g[i] || (tlb_asid[i] == cur_asid));
        end
    end

    // lowest matching index wins
    always_comb begin
        sel_idx = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                sel_idx = IDX_W'(i);
            end
        end
    end

    assign hit = |match;
    assign ppn = tlb_ppn[sel_idx][search_odd];
    assign plv = tlb_plv[sel_idx][search_odd];
    assign v   = tlb_v[sel_idx][search_odd];
    assign d   = tlb_d[sel_idx][search_odd];

endmodule

//--- la_mmu_ctrl.sv
`timescale 1ns/100ps

module la_mmu_ctrl #(
    parameter int CREDITS = 4
) (
    input  logic clk,
    input  logic rst_n,

    // request side
    input  logic in_valid,
    output logic in_ready,

    // result side
    input  logic credit_return,
    output logic out_valid,

    // stage register enables
    output logic s1_load,
    output logic s2_load
);

    localparam int CNT_W = $clog2(CREDITS + 1);

    logic             s1_valid;
    logic             s2_valid;
    logic [CNT_W-1:0] credit_cnt;
    logic             s2_free;
    logic             s1_adv;

    // stage 2 only emits while the sink has a free slot
    assign out_valid = s2_valid && (credit_cnt != '0);

    // stage 2 can take a new item when empty or emitting
    assign s2_free = !s2_valid || out_valid;
    assign s1_adv  = s1_valid && s2_free;

    assign in_ready = !s1_valid || s1_adv;
    assign s1_load  = in_valid && in_ready;
    assign s2_load  = s1_adv;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else if (s1_load) begin
            s1_valid <= 1'b1;
        end else if (s1_adv) begin
            s1_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s2_valid <= 1'b0;
        end else if (s2_load) begin
            s2_valid <= 1'b1;
        end else if (out_valid) begin
            s2_valid <= 1'b0;
        end
    end

    // one credit per result out, one back per credit_return
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit_cnt <= CNT_W'(CREDITS);
        end else if (out_valid && !credit_return) begin
            credit_cnt <= credit_cnt - 1'b1;
        end else if (credit_return && !out_valid) begin
            credit_cnt <= credit_cnt + 1'b1;
        end
    end

endmodule

//--- la_mmu_pkg.sv
package la_mmu_pkg;

    // address widths
    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;

    // page pair number, va[31:13]
    typedef logic [18:0] vppn_t;

    // 4 KB physical page number
    typedef logic [19:0] ppn_t;

    typedef logic [9:0] asid_t;
    typedef logic [1:0] plv_t;

    // window segment, top 3 address bits
    typedef logic [2:0] seg_t;

    typedef logic [5:0] ecode_t;

    // in-page offset for 4 KB pages
    localparam int PAGE_OFS_W = 12;

    // privilege levels that have a window enable bit
    localparam plv_t PLV_KERNEL = 2'd0;
    localparam plv_t PLV_USER   = 2'd3;

    // exception codes
    localparam ecode_t ECODE_NONE = 6'h00;

    // load page invalid
    localparam ecode_t ECODE_PIL  = 6'h01;

    // store page invalid
    localparam ecode_t ECODE_PIS  = 6'h02;

    // store to a clean page
    localparam ecode_t ECODE_PME  = 6'h04;

    // page privilege violation
    localparam ecode_t ECODE_PPI  = 6'h07;

    // no tlb entry, refill
    localparam ecode_t ECODE_TLBR = 6'h3f;

endpackage
